/* sdram_cmd_pkg.sv */
/*
 * device command codes and mode register layout on address bus a
 * commands are {ras, cas, we} with cs low; cs high always means NOP
 */
`default_nettype none

package sdram_cmd_pkg;

    typedef enum logic [2:0] {
        LOAD_MODE = 3'b000,
        ACTIVE    = 3'b011,
        WRITE     = 3'b100,
        READ      = 3'b101,
        NOP       = 3'b111
    } sdram_cmd_t;

    // mode register fields, 3 bits each
    localparam int MODE_CL_LSB = 4;     // cas latency
    localparam int MODE_BL_LSB = 0;     // burst code, length = 2**code

    // idle cycles between reset release and LOAD MODE
    localparam int INIT_CYCLES = 8;

endpackage

`default_nettype wire

/* sdram_geom_pkg.sv */
/*
 * small device geometry so the model array stays cheap to simulate
 * request address is {bank, row, col}, msb first
 */
`default_nettype none

package sdram_geom_pkg;

    localparam int BANK_W = 2;
    localparam int ROW_W  = 4;
    localparam int COL_W  = 5;
    localparam int DQ_W   = 16;

    localparam int ADDR_W = BANK_W + ROW_W + COL_W;

    // pin bus must also hold the mode fields up to bit 6
    localparam int A_W = (ROW_W > 7) ? ROW_W : 7;

endpackage

`default_nettype wire

/* sdram_model.sv */
/*
 * behavioral SDRAM, sequential bursts only, no refresh or precharge
 * cas latency and burst length come from LOAD MODE alone
 * dqm masks bytes on writes; read beats are driven on the full word
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_model
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;
(
    input  logic                clk,
    input  logic                cke,
    input  logic                cs,
    input  logic                ras,
    input  logic                cas,
    input  logic                we,
    input  logic [A_W-1:0]      a,
    input  logic [BANK_W-1:0]   ba,
    input  logic [DQ_W/8-1:0]   dqm,
    inout  wire  [DQ_W-1:0]     dq
);

    logic [DQ_W-1:0] mem [2**BANK_W][2**ROW_W][2**COL_W];

    sdram_cmd_t       cmd;
    logic [2:0]       cl_q;                       // cas latency
    logic [3:0]       bl_q;                       // burst length in beats
    logic [ROW_W-1:0] row_q [2**BANK_W];          // open row per bank

    logic [3:0]        wr_left;
    logic [BANK_W-1:0] wr_bank;
    logic [ROW_W-1:0]  wr_row;
    logic [COL_W-1:0]  wr_col;

    logic              rd_busy;
    logic [3:0]        rd_cnt;                    // cycles since READ
    logic [BANK_W-1:0] rd_bank;
    logic [ROW_W-1:0]  rd_row;
    logic [COL_W-1:0]  rd_col;
    logic [4:0]        rd_last;
    logic              rd_drive;

    logic              w_en;
    logic [BANK_W-1:0] w_bank;
    logic [ROW_W-1:0]  w_row;
    logic [COL_W-1:0]  w_col;

    assign cmd = cs ? NOP : sdram_cmd_t'({ras, cas, we});

    assign rd_last  = 5'(cl_q) + 5'(bl_q) - 5'd1;
    assign rd_drive = rd_busy && (5'(rd_cnt) >= 5'(cl_q));
    assign dq = rd_drive ? mem[rd_bank][rd_row][rd_col + COL_W'(rd_cnt - 4'(cl_q))]
                         : 'z;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cl_q    <= 3'd2;
            bl_q    <= 4'd1;
            wr_left <= '0;
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
        end else begin
            if (cmd == LOAD_MODE) begin
                cl_q <= a[MODE_CL_LSB +: 3];
                bl_q <= 4'(1 << a[MODE_BL_LSB +: 3]);
            end
            if (cmd == WRITE)
                wr_left <= bl_q - 4'd1;                // beat 0 stored with the command
            else if (wr_left != 0)
                wr_left <= wr_left - 4'd1;
            if (cmd == READ) begin
                rd_busy <= 1'b1;
                rd_cnt  <= 4'd1;
            end else if (rd_busy) begin
                if (5'(rd_cnt) == rd_last)
                    rd_busy <= 1'b0;                   // last beat out, release dq
                else
                    rd_cnt <= rd_cnt + 4'd1;
            end
        end
    end

    // addresses latched with the command
    always_ff @(posedge clk) begin
        if (cmd == ACTIVE)
            row_q[ba] <= a[ROW_W-1:0];
        if (cmd == WRITE) begin
            wr_bank <= ba;
            wr_row  <= row_q[ba];
            wr_col  <= a[COL_W-1:0] + COL_W'(1);
        end else if (wr_left != 0) begin
            wr_col <= wr_col + COL_W'(1);
        end
        if (cmd == READ) begin
            rd_bank <= ba;
            rd_row  <= row_q[ba];
            rd_col  <= a[COL_W-1:0];
        end
    end

    assign w_en   = (cmd == WRITE) || (wr_left != 0);
    assign w_bank = (cmd == WRITE) ? ba : wr_bank;
    assign w_row  = (cmd == WRITE) ? row_q[ba] : wr_row;
    assign w_col  = (cmd == WRITE) ? a[COL_W-1:0] : wr_col;

    always_ff @(posedge clk) begin
        if (w_en) begin
            for (int i = 0; i < DQ_W / 8; i++) begin
                if (!dqm[i])
                    mem[w_bank][w_row][w_col][i*8 +: 8] <= dq[i*8 +: 8];
            end
        end
    end

    // tRCD of two cycles
    a_act_gap: assert property (@(posedge clk) disable iff (!cke)
        (cmd == ACTIVE) |=> !(cmd inside {READ, WRITE}))
        else $error("read or write right after ACTIVE");

endmodule

`default_nettype wire

/* sdram_ctrl.sv */
/*
 * single-access SDRAM controller: ACTIVE, NOP, then one READ or WRITE burst
 * every access reopens its row; no refresh, no precharge
 * wdata must show the current beat and advance after each wr_next
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;
#(
    parameter int CAS_LAT   = 2,
    parameter int BURST_LEN = 4
) (
    input  logic               clk,
    input  logic               cke,
    input  logic               start,
    input  logic               we_in,
    input  logic [DQ_W/8-1:0]  be,
    input  logic [ADDR_W-1:0]  addr,
    input  logic [DQ_W-1:0]    wdata,
    output logic               busy,
    output logic               ready,
    output logic               wr_next,
    output logic               rd_valid,
    output logic               done,
    output logic [DQ_W-1:0]    rd_data,
    output logic               cs,
    output logic               ras,
    output logic               cas,
    output logic               we,
    output logic [A_W-1:0]     a,
    output logic [BANK_W-1:0]  ba,
    output logic [DQ_W/8-1:0]  dqm,
    inout  wire  [DQ_W-1:0]    dq
);

    typedef enum logic [2:0] {
        INIT_WAIT, MODE, IDLE, ACT, GAP, WR_BURST, RD_WAIT, RD_BURST
    } state_t;

    localparam int CNT_W = $clog2(INIT_CYCLES + 1);
    localparam logic [A_W-1:0] MODE_WORD =
        A_W'((CAS_LAT << MODE_CL_LSB) | ($clog2(BURST_LEN) << MODE_BL_LSB));

    state_t            state;
    sdram_cmd_t        cmd_q;
    logic [CNT_W-1:0]  cnt;                      // init and cas wait
    logic [3:0]        beat;
    logic [COL_W-1:0]  col;                      // column of current beat
    logic              dq_oe;

    logic [BANK_W-1:0] bank_in;
    logic [ROW_W-1:0]  row_in;
    logic [COL_W-1:0]  col_in;

    assign bank_in = addr[ADDR_W-1 -: BANK_W];
    assign row_in  = addr[COL_W +: ROW_W];
    assign col_in  = addr[COL_W-1:0];

    assign cs              = (cmd_q == NOP);
    assign {ras, cas, we}  = cmd_q;
    assign busy            = (state != IDLE);
    assign wr_next         = dq_oe;             // beat on dq is taken this cycle
    assign dq              = dq_oe ? wdata : 'z;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state    <= INIT_WAIT;
            cmd_q    <= NOP;
            cnt      <= '0;
            beat     <= '0;
            col      <= '0;
            a        <= '0;
            ba       <= '0;
            dqm      <= '1;
            dq_oe    <= 1'b0;
            rd_valid <= 1'b0;
            done     <= 1'b0;
            ready    <= 1'b0;
        end else begin
            cmd_q    <= NOP;
            rd_valid <= 1'b0;
            done     <= 1'b0;
            case (state)
                INIT_WAIT: begin
                    if (cnt == CNT_W'(INIT_CYCLES - 1)) begin
                        state <= MODE;
                        cmd_q <= LOAD_MODE;
                        a     <= MODE_WORD;
                        ba    <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                MODE: begin
                    state <= IDLE;
                    ready <= 1'b1;
                end
                IDLE: begin
                    if (start) begin
                        state <= ACT;
                        cmd_q <= ACTIVE;
                        ba    <= bank_in;
                        a     <= A_W'(row_in);
                    end
                end
                ACT: state <= GAP;               // NOP cycle for tRCD
                GAP: begin
                    a    <= A_W'(col_in);
                    col  <= col_in;
                    beat <= '0;
                    cnt  <= '0;
                    if (we_in) begin
                        state <= WR_BURST;
                        cmd_q <= WRITE;
                        dq_oe <= 1'b1;           // beat 0 rides with WRITE
                        dqm   <= ~be;
                    end else begin
                        state <= RD_WAIT;
                        cmd_q <= READ;
                        dqm   <= '0;
                    end
                end
                WR_BURST: begin
                    a   <= A_W'(col + 1'b1);     // ignored by device on NOP
                    col <= col + 1'b1;
                    if (beat == 4'(BURST_LEN - 1)) begin
                        state <= IDLE;
                        dq_oe <= 1'b0;
                        dqm   <= '1;
                        done  <= 1'b1;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                RD_WAIT: begin
                    if (cnt == CNT_W'(CAS_LAT - 1))
                        state <= RD_BURST;
                    else
                        cnt <= cnt + 1'b1;
                end
                RD_BURST: begin
                    rd_valid <= 1'b1;
                    a        <= A_W'(col + 1'b1);
                    col      <= col + 1'b1;
                    if (beat == 4'(BURST_LEN - 1)) begin
                        state <= IDLE;
                        dqm   <= '1;
                        done  <= 1'b1;           // with the last rd_valid
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_BURST)
            rd_data <= dq;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!cke)
        start |-> !busy)
        else $error("start while controller busy");

    a_no_drive_on_read: assert property (@(posedge clk) disable iff (!cke)
        (state inside {RD_WAIT, RD_BURST}) |-> !dq_oe)
        else $error("controller drives dq during a read");

endmodule

`default_nettype wire

/* port_arbiter.sv */
/*
 * two-port round-robin arbiter, grant held until the controller's done
 * port 0 wins the first tie after reset
 */
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
    import sdram_geom_pkg::*;
(
    input  logic               clk,
    input  logic               cke,
    input  logic               req_0,
    input  logic               we_0,
    input  logic [ADDR_W-1:0]  addr_0,
    input  logic [DQ_W/8-1:0]  be_0,
    input  logic [DQ_W-1:0]    wdata_0,
    output logic               wr_next_0,
    output logic               rd_valid_0,
    output logic               done_0,
    input  logic               req_1,
    input  logic               we_1,
    input  logic [ADDR_W-1:0]  addr_1,
    input  logic [DQ_W/8-1:0]  be_1,
    input  logic [DQ_W-1:0]    wdata_1,
    output logic               wr_next_1,
    output logic               rd_valid_1,
    output logic               done_1,
    output logic               start,
    output logic               we_out,
    output logic [ADDR_W-1:0]  addr_out,
    output logic [DQ_W/8-1:0]  be_out,
    output logic [DQ_W-1:0]    wdata_out,
    input  logic               busy,
    input  logic               wr_next,
    input  logic               rd_valid,
    input  logic               done
);

    logic [1:0] grant;
    logic       last;                            // 1 when port 1 served last
    logic       pick_1;
    logic       sel;

    assign pick_1 = req_1 && (!req_0 || !last);
    assign sel    = grant[1];

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            grant <= 2'b00;
            last  <= 1'b1;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (done) begin
                grant <= 2'b00;                  // regrant no earlier than next cycle
            end else if (grant == 2'b00 && !busy && (req_0 || req_1)) begin
                grant <= pick_1 ? 2'b10 : 2'b01;
                last  <= pick_1;
                start <= 1'b1;
            end
        end
    end

    assign we_out    = sel ? we_1    : we_0;
    assign addr_out  = sel ? addr_1  : addr_0;
    assign be_out    = sel ? be_1    : be_0;
    assign wdata_out = sel ? wdata_1 : wdata_0;

    assign wr_next_0  = wr_next  & grant[0];
    assign rd_valid_0 = rd_valid & grant[0];
    assign done_0     = done     & grant[0];
    assign wr_next_1  = wr_next  & grant[1];
    assign rd_valid_1 = rd_valid & grant[1];
    assign done_1     = done     & grant[1];

    a_grant_onehot: assert property (@(posedge clk) disable iff (!cke)
        $onehot0(grant))
        else $error("both ports granted");

    a_done_granted: assert property (@(posedge clk) disable iff (!cke)
        done |-> (grant != 2'b00))
        else $error("controller done with no port granted");

endmodule

`default_nettype wire

/* sdram_subsys_top.sv */
/*
 * two request ports sharing one SDRAM through the arbiter
 * rd_data is common; rd_valid_n tells which port owns a beat
 * CAS_LAT 2 or 3, BURST_LEN 1, 2, 4 or 8
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_top
    import sdram_geom_pkg::*;
#(
    parameter int CAS_LAT   = 2,
    parameter int BURST_LEN = 4
) (
    input  logic               clk,
    input  logic               cke,
    input  logic               req_0,
    input  logic               we_0,
    input  logic [ADDR_W-1:0]  addr_0,
    input  logic [DQ_W/8-1:0]  be_0,
    input  logic [DQ_W-1:0]    wdata_0,
    output logic               wr_next_0,
    output logic               rd_valid_0,
    output logic               done_0,
    input  logic               req_1,
    input  logic               we_1,
    input  logic [ADDR_W-1:0]  addr_1,
    input  logic [DQ_W/8-1:0]  be_1,
    input  logic [DQ_W-1:0]    wdata_1,
    output logic               wr_next_1,
    output logic               rd_valid_1,
    output logic               done_1,
    output logic [DQ_W-1:0]    rd_data,
    output logic               ready
);

    logic              arb_start;
    logic              arb_we;
    logic [ADDR_W-1:0] arb_addr;
    logic [DQ_W/8-1:0] arb_be;
    logic [DQ_W-1:0]   arb_wdata;
    logic              ctl_busy;
    logic              ctl_wr_next;
    logic              ctl_rd_valid;
    logic              ctl_done;

    logic              sd_cs;
    logic              sd_ras;
    logic              sd_cas;
    logic              sd_we;
    logic [A_W-1:0]    sd_a;
    logic [BANK_W-1:0] sd_ba;
    logic [DQ_W/8-1:0] sd_dqm;
    wire  [DQ_W-1:0]   sd_dq;

    port_arbiter u_arb (
        .clk        (clk),
        .cke        (cke),
        .req_0      (req_0),
        .we_0       (we_0),
        .addr_0     (addr_0),
        .be_0       (be_0),
        .wdata_0    (wdata_0),
        .wr_next_0  (wr_next_0),
        .rd_valid_0 (rd_valid_0),
        .done_0     (done_0),
        .req_1      (req_1),
        .we_1       (we_1),
        .addr_1     (addr_1),
        .be_1       (be_1),
        .wdata_1    (wdata_1),
        .wr_next_1  (wr_next_1),
        .rd_valid_1 (rd_valid_1),
        .done_1     (done_1),
        .start      (arb_start),
        .we_out     (arb_we),
        .addr_out   (arb_addr),
        .be_out     (arb_be),
        .wdata_out  (arb_wdata),
        .busy       (ctl_busy),
        .wr_next    (ctl_wr_next),
        .rd_valid   (ctl_rd_valid),
        .done       (ctl_done)
    );

    sdram_ctrl #(
        .CAS_LAT   (CAS_LAT),
        .BURST_LEN (BURST_LEN)
    ) u_ctrl (
        .clk      (clk),
        .cke      (cke),
        .start    (arb_start),
        .we_in    (arb_we),
        .be       (arb_be),
        .addr     (arb_addr),
        .wdata    (arb_wdata),
        .busy     (ctl_busy),
        .ready    (ready),
        .wr_next  (ctl_wr_next),
        .rd_valid (ctl_rd_valid),
        .done     (ctl_done),
        .rd_data  (rd_data),
        .cs       (sd_cs),
        .ras      (sd_ras),
        .cas      (sd_cas),
        .we       (sd_we),
        .a        (sd_a),
        .ba       (sd_ba),
        .dqm      (sd_dqm),
        .dq       (sd_dq)
    );

    sdram_model u_sdram (
        .clk (clk),
        .cke (cke),
        .cs  (sd_cs),
        .ras (sd_ras),
        .cas (sd_cas),
        .we  (sd_we),
        .a   (sd_a),
        .ba  (sd_ba),
        .dqm (sd_dqm),
        .dq  (sd_dq)
    );

endmodule

`default_nettype wire

/* tb_checker.sv */
/*
 * watches both request ports and keeps the shadow memory from wr_next beats
 * predicts the round-robin winner from the request levels seen before start
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import sdram_geom_pkg::*;
#(
    parameter int BURST_LEN = 4
) (
    input  logic               clk,
    input  logic               cke,
    input  logic               ready,
    input  logic               start,
    input  int                 test_num,
    input  logic [1:0]         req,
    input  logic [1:0]         we,
    input  logic [ADDR_W-1:0]  addr_0,
    input  logic [ADDR_W-1:0]  addr_1,
    input  logic [DQ_W/8-1:0]  be_0,
    input  logic [DQ_W/8-1:0]  be_1,
    input  logic [DQ_W-1:0]    wdata_0,
    input  logic [DQ_W-1:0]    wdata_1,
    input  logic [1:0]         wr_next,
    input  logic [1:0]         rd_valid,
    input  logic [1:0]         done,
    input  logic [DQ_W-1:0]    rd_data,
    output int                 errors,
    output int                 checks
);

    logic [DQ_W-1:0]   shadow [2**ADDR_W];
    logic [1:0]        req_q;                    // levels seen one edge earlier
    logic              last;                     // port served last
    logic              active;
    int                own;
    logic              acc_we;
    logic [ADDR_W-1:0] acc_addr;
    logic [DQ_W/8-1:0] acc_be;
    int                wcnt;
    int                rcnt;
    int                cyc;
    int                st_cyc;
    int                cur_test;
    int                test_err;

    function automatic string test_name(input int n);
        case (n)
            1: return "init and ready";
            2: return "full burst write and read-back";
            3: return "partial byte enables";
            4: return "random traffic on both ports";
            5: return "round-robin on ties";
            6: return "write burst length and timing";
            default: return "unknown";
        endcase
    endfunction

    task automatic fail_value(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
        $display("[ERROR] %s: expected %h, got %h", what, exp, got);
        errors++;
        test_err++;
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp,
                            input logic [31:0] got);
        checks++;
        if (exp !== got)
            fail_value(what, exp, got);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        cur_test = 0;
        test_err = 0;
        cyc      = 0;
    end

    always @(posedge clk) begin
        logic [DQ_W-1:0]   wd;
        logic [ADDR_W-1:0] ix;
        cyc++;
        if (test_num != cur_test) begin
            if (cur_test > 0)
                $display("test %0d (%s): %0d errors",
                         cur_test, test_name(cur_test), test_err);
            cur_test = test_num;
            test_err = 0;
        end
        if (!cke) begin
            last   = 1'b1;                       // port 0 wins the first tie
            active = 1'b0;
            req_q  = 2'b00;
        end else begin
            if (start) begin
                if (active) begin
                    $display("start seen while an access is still open");
                    errors++;
                    test_err++;
                end
                if (req_q == 2'b00) begin
                    $display("start seen with no port requesting");
                    errors++;
                    test_err++;
                end
                own      = (req_q == 2'b11) ? int'(!last) : int'(req_q[1]);
                active   = 1'b1;
                st_cyc   = cyc;
                wcnt     = 0;
                rcnt     = 0;
                acc_we   = we[own];
                acc_addr = own ? addr_1 : addr_0;
                acc_be   = own ? be_1 : be_0;
            end
            if (wr_next[own] && active) begin
                wd = own ? wdata_1 : wdata_0;
                ix = acc_addr + ADDR_W'(wcnt);
                for (int i = 0; i < DQ_W / 8; i++) begin
                    if (acc_be[i])
                        shadow[ix][i*8 +: 8] = wd[i*8 +: 8];
                end
                wcnt++;
            end
            if (rd_valid[own] && active) begin
                check_eq($sformatf("rd_data port %0d addr %h", own, acc_addr + ADDR_W'(rcnt)),
                         shadow[acc_addr + ADDR_W'(rcnt)], rd_data);
                rcnt++;
            end
            if (!ready)
                check_eq("wr_next/rd_valid/done before ready", 0, {wr_next, rd_valid, done});
            else if (!active)
                check_eq("wr_next/rd_valid/done with no access open", 0,
                         {wr_next, rd_valid, done});
            else
                check_eq("wr_next/rd_valid/done on the idle port", 0,
                         {wr_next[!own], rd_valid[!own], done[!own]});
            if (done[own] && active) begin
                if (acc_we) begin
                    check_eq($sformatf("wr_next count port %0d", own), BURST_LEN, wcnt);
                    check_eq($sformatf("done_%0d cycles after start", own),
                             BURST_LEN + 3, cyc - st_cyc);
                end else begin
                    check_eq($sformatf("rd_valid count port %0d", own), BURST_LEN, rcnt);
                    check_eq($sformatf("rd_valid_%0d with done", own), 1, rd_valid[own]);
                end
                last   = own[0];
                active = 1'b0;
            end
            req_q = req;
        end
    end

endmodule

`default_nettype wire

/* tb_sdram_subsys.sv */
/*
 * drives both request ports from a 16-bit Fibonacci LFSR, seed 92
 * reads stay inside a window that test 2 fills first, so no read sees X
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_subsys
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;
;

    localparam int CAS_LAT   = 2;
    localparam int BURST_LEN = 4;
    localparam int WAIT_MAX  = 200;               // cycles per wait loop

    logic              clk;
    logic              cke;
    logic [1:0]        req;
    logic [1:0]        we_s;
    logic [ADDR_W-1:0] addr_s [2];
    logic [DQ_W/8-1:0] be_s [2];
    logic [DQ_W-1:0]   wdata_s [2];
    logic [1:0]        wr_next_o;
    logic [1:0]        rd_valid_o;
    logic [1:0]        done_o;
    logic [DQ_W-1:0]   rd_data;
    logic              ready;
    logic [15:0]       lfsr;
    int                test_num;
    int                errors;
    int                checks;

    sdram_subsys_top #(
        .CAS_LAT   (CAS_LAT),
        .BURST_LEN (BURST_LEN)
    ) uut (
        .clk (clk), .cke (cke),
        .req_0 (req[0]), .we_0 (we_s[0]), .addr_0 (addr_s[0]), .be_0 (be_s[0]),
        .wdata_0 (wdata_s[0]), .wr_next_0 (wr_next_o[0]), .rd_valid_0 (rd_valid_o[0]),
        .done_0 (done_o[0]),
        .req_1 (req[1]), .we_1 (we_s[1]), .addr_1 (addr_s[1]), .be_1 (be_s[1]),
        .wdata_1 (wdata_s[1]), .wr_next_1 (wr_next_o[1]), .rd_valid_1 (rd_valid_o[1]),
        .done_1 (done_o[1]),
        .rd_data (rd_data), .ready (ready)
    );

    tb_checker #(.BURST_LEN(BURST_LEN)) chk (
        .clk (clk), .cke (cke), .ready (ready), .start (uut.arb_start),
        .test_num (test_num), .req (req), .we (we_s),
        .addr_0 (addr_s[0]), .addr_1 (addr_s[1]), .be_0 (be_s[0]), .be_1 (be_s[1]),
        .wdata_0 (wdata_s[0]), .wdata_1 (wdata_s[1]),
        .wr_next (wr_next_o), .rd_valid (rd_valid_o), .done (done_o),
        .rd_data (rd_data), .errors (errors), .checks (checks)
    );

    always #4 clk = ~clk;

    // taps 16, 14, 13, 11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    // window covers any bank, rows 4..7 and two bursts per row
    function automatic logic [ADDR_W-1:0] window_addr(input logic [4:0] sel);
        logic [COL_W-1:0] col;
        col = COL_W'(sel[0] * BURST_LEN);
        return {sel[4:3], 2'b01, sel[2:1], col};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic access(input int p, input logic w, input logic [ADDR_W-1:0] ad,
                          input logic [DQ_W/8-1:0] b);
        logic [DQ_W-1:0] data [8];
        int              idx;
        int              t;
        logic            got_wr;
        logic            got_done;
        for (int i = 0; i < BURST_LEN; i++)
            data[i] = DQ_W'(rand_bits(DQ_W));
        @(posedge clk);
        #1;
        req[p]     = 1'b1;
        we_s[p]    = w;
        addr_s[p]  = ad;
        be_s[p]    = b;
        wdata_s[p] = data[0];
        idx = 0;
        t   = 0;
        got_done = 1'b0;
        while (!got_done) begin
            @(posedge clk);
            got_wr   = wr_next_o[p];
            got_done = done_o[p];
            if (got_wr && !got_done) begin
                idx++;
                #1;
                if (idx < BURST_LEN)
                    wdata_s[p] = data[idx];
            end
            t++;
            if (t > WAIT_MAX)
                abort_run($sformatf("timeout waiting for done on port %0d", p));
        end
        #1;
        req[p] = 1'b0;
    endtask

    task automatic random_traffic(input int p, input int n);
        for (int i = 0; i < n; i++)
            access(p, rand_bits(1), window_addr(rand_bits(5)), rand_bits(2));
    endtask

    initial begin
        int n;
        clk      = 1'b0;
        cke      = 1'b0;
        req      = '0;
        we_s     = '0;
        addr_s   = '{default: '0};
        be_s     = '{default: '0};
        wdata_s  = '{default: '0};
        lfsr     = 16'd92;
        test_num = 1;
        repeat (5) @(posedge clk);
        #1;
        cke = 1'b1;

        n = 0;
        while (!ready) begin
            @(posedge clk);
            n++;
            if (n > INIT_CYCLES + 6)
                abort_run("ready did not rise after init");
        end

        test_num = 2;
        for (int s = 0; s < 32; s++) begin
            access(0, 1'b1, window_addr(s), 2'b11);
            access(0, 1'b0, window_addr(s), 2'b11);
        end

        test_num = 3;
        for (int i = 0; i < 12; i++) begin
            logic [ADDR_W-1:0] ad;
            ad = window_addr(rand_bits(5));
            access(0, 1'b1, ad, rand_bits(1) ? 2'b01 : 2'b10);
            access(0, 1'b0, ad, 2'b11);
        end

        test_num = 4;
        fork
            random_traffic(0, 40);
            random_traffic(1, 40);
        join

        test_num = 5;
        repeat (6) begin
            fork
                access(0, 1'b0, window_addr(rand_bits(5)), 2'b11);
                access(1, 1'b0, window_addr(rand_bits(5)), 2'b11);
            join
        end

        test_num = 6;
        for (int i = 0; i < 8; i++)
            access(1, 1'b1, window_addr(rand_bits(5)), 2'b11);

        test_num = 7;
        repeat (2) @(posedge clk);
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
sdram_cmd_pkg.sv
sdram_geom_pkg.sv
sdram_model.sv
sdram_ctrl.sv
port_arbiter.sv
sdram_subsys_top.sv
tb_checker.sv
tb_sdram_subsys.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module tb_sdram_subsys -o sim_sdram

out=$(./obj_dir/sim_sdram)
echo "$out"
echo "$out" | grep -qF '** PASS **'
